/* filelist.f */
design/sa_geom_pkg.sv
design/sa_word_pkg.sv
design/sa_feed_if.sv
design/sa_pe.sv
design/sa_ctrl.sv
design/data_buffer.sv
design/weight_bram.sv
design/systolic_array.sv
design/out_collector.sv
design/sa_top.sv
tests/tb_sa_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the systolic array testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sa_top -Mdir "$BUILD_DIR" -o tb_sa_top -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_sa_top" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Run failed, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Run passed"
exit 0

/* tests/tb_sa_top.sv */
`timescale 1ns/1ps
// Testbench for the systolic array top level
// Host writes into both memories, burst runs and a reference dot-product model
module tb_sa_top;
    import sa_geom_pkg::*;
    import sa_word_pkg::*;

    localparam int SEED     = 20409;
    localparam int WAIT_MAX = 400;
    localparam int SUM_W    = N_COL * ACC_W;

    logic               clk;
    logic               rst_n;
    logic               start_i;
    len_t               burst_len_i;
    logic               wr_en_i;
    logic [HADDR_W-1:0] wr_addr_i;
    logic [ACT_W-1:0]   wr_data_i;
    logic [SUM_W-1:0]   acc_data_o;
    logic               acc_valid_o;
    logic               done_o;
    logic               busy_o;

    // Reference copies of both memories
    int unsigned        data_mem [DATA_DEPTH][N_ROW];
    int unsigned        wgt_mem [N_COL][N_ROW];
    logic [SUM_W-1:0]   exp_q [$];
    int unsigned        seed_val;

    sa_top #(.N_ROW(N_ROW), .N_COL(N_COL), .DATA_DEPTH(DATA_DEPTH)) u_sa_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .burst_len_i (burst_len_i),
        .wr_en_i     (wr_en_i),
        .wr_addr_i   (wr_addr_i),
        .wr_data_i   (wr_data_i),
        .acc_data_o  (acc_data_o),
        .acc_valid_o (acc_valid_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    always #4 clk = ~clk;

    // Per column sum over rows of activation times weight
    function automatic logic [SUM_W-1:0] dot_products(input int v);
        logic [SUM_W-1:0] res;
        int unsigned      sum;
        res = '0;
        for (int c = 0; c < N_COL; c++) begin
            sum = 0;
            for (int r = 0; r < N_ROW; r++) begin
                sum += data_mem[v][r] * wgt_mem[c][r];
            end
            res[c*ACC_W +: ACC_W] = ACC_W'(sum);
        end
        return res;
    endfunction

    // Outputs sampled on the falling edge away from the register updates
    always @(negedge clk) begin : check_results
        logic [SUM_W-1:0] exp_vec;
        string            why;
        int               bad_col;
        exp_vec = '0;
        why     = "";
        bad_col = -1;
        if (rst_n && done_o && !acc_valid_o) begin
            why = "done_o pulsed without a result";
        end
        if (rst_n && acc_valid_o) begin
            if (exp_q.size() == 0) begin
                why = "a result appeared with no run pending";
            end else begin
                exp_vec = exp_q.pop_front();
                for (int c = 0; c < N_COL; c++) begin
                    if (bad_col < 0 &&
                        acc_data_o[c*ACC_W +: ACC_W] !== exp_vec[c*ACC_W +: ACC_W]) begin
                        bad_col = c;
                    end
                end
                if (done_o && exp_q.size() != 0) begin
                    why = "done_o pulsed while results were still expected";
                end
            end
        end
        assert (why == "" && bad_col < 0) else begin
            if (bad_col >= 0) begin
                $display("FAILED t=%0t acc_data_o[%0d] got %0d expected %0d", $time, bad_col,
                         acc_data_o[bad_col*ACC_W +: ACC_W], exp_vec[bad_col*ACC_W +: ACC_W]);
            end else begin
                $display("Error at t=%0t: %s", $time, why);
            end
            $display("Simulation finished: FAIL");
            $fatal(1, "result check");
        end
    end

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            $display("FAILED t=%0t %s got %b expected 0", $time, name, value);
            $display("Simulation finished: FAIL");
            $fatal(1, "signal not low");
        end
    endtask

    task automatic check_high(input string name, input logic value);
        assert (value === 1'b1) else begin
            $display("FAILED t=%0t %s got %b expected 1", $time, name, value);
            $display("Simulation finished: FAIL");
            $fatal(1, "signal not high");
        end
    endtask

    task automatic check_idle();
        check_low("acc_valid_o", acc_valid_o);
        check_low("done_o", done_o);
        check_low("busy_o", busy_o);
    endtask

    task automatic write_byte(input logic [HADDR_W-1:0] addr, input logic [7:0] val);
        @(posedge clk);
        wr_en_i   <= 1'b1;
        wr_addr_i <= addr;
        wr_data_i <= val;
        @(posedge clk);
        wr_en_i   <= 1'b0;
    endtask

    // Data side has the select bit low and the vector index above the row field
    task automatic write_act(input int v, input int r, input int unsigned val);
        logic [HADDR_W-1:0] addr;
        addr = '0;
        addr[VEC_LSB +: VEC_W] = VEC_W'(v);
        addr[ROW_W-1:0]        = ROW_W'(r);
        data_mem[v][r] = val & 32'hff;
        write_byte(addr, 8'(val));
    endtask

    task automatic write_wgt(input int c, input int r, input int unsigned val);
        logic [HADDR_W-1:0] addr;
        addr = '0;
        addr[SEL_BIT]          = 1'b1;
        addr[COL_LSB +: COL_W] = COL_W'(c);
        addr[ROW_W-1:0]        = ROW_W'(r);
        wgt_mem[c][r] = val & 32'hff;
        write_byte(addr, 8'(val));
    endtask

    task automatic fill_acts(input int len, input bit all_ones);
        for (int v = 0; v < len; v++) begin
            for (int r = 0; r < N_ROW; r++) begin
                write_act(v, r, all_ones ? 255 : $urandom_range(255));
            end
        end
    endtask

    task automatic fill_wgts(input bit all_ones);
        for (int c = 0; c < N_COL; c++) begin
            for (int r = 0; r < N_ROW; r++) begin
                write_wgt(c, r, all_ones ? 255 : $urandom_range(255));
            end
        end
    endtask

    task automatic wait_done(input int len);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (done_o !== 1'b1 && n < WAIT_MAX);
        assert (done_o === 1'b1) else begin
            $display("Timeout: no done_o within %0d cycles of a %0d-vector burst", WAIT_MAX, len);
            $display("Simulation finished: FAIL");
            $fatal(1, "done timeout");
        end
    endtask

    // Optional second start some cycles in with a different length
    task automatic run_burst(input int len, input int restart_at);
        for (int v = 0; v < len; v++) begin
            exp_q.push_back(dot_products(v));
        end
        @(posedge clk);
        start_i     <= 1'b1;
        burst_len_i <= len_t'(len);
        @(posedge clk);
        start_i     <= 1'b0;
        if (restart_at > 0) begin
            repeat (restart_at) @(posedge clk);
            start_i     <= 1'b1;
            burst_len_i <= len_t'(3);
            @(posedge clk);
            start_i     <= 1'b0;
        end
        wait_done(len);
        check_high("busy_o", busy_o);
        @(negedge clk);
        check_low("busy_o", busy_o);
    endtask

    initial begin
        int len;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start_i     = 1'b0;
        burst_len_i = '0;
        wr_en_i     = 1'b0;
        wr_addr_i   = '0;
        wr_data_i   = '0;
        seed_val    = $urandom(SEED);

        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_idle();
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle();

        // Hand-chosen weights and four small vectors
        for (int c = 0; c < N_COL; c++) begin
            for (int r = 0; r < N_ROW; r++) begin
                write_wgt(c, r, (c + 1) * (r + 1));
            end
        end
        for (int v = 0; v < 4; v++) begin
            for (int r = 0; r < N_ROW; r++) begin
                write_act(v, r, 10 * v + r + 1);
            end
        end
        run_burst(4, 0);

        for (int k = 0; k < 5; k++) begin
            len = $urandom_range(DATA_DEPTH, 1);
            fill_wgts(1'b0);
            fill_acts(len, 1'b0);
            run_burst(len, 0);
        end

        // Extra start lands in STREAM
        fill_acts(20, 1'b0);
        run_burst(20, N_ROW + 2);

        // New weights over the same data
        fill_wgts(1'b0);
        run_burst(20, 0);

        // Largest operands whose sums must not wrap
        fill_wgts(1'b1);
        fill_acts(8, 1'b1);
        run_burst(8, 0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* design/sa_top.sv */
`timescale 1ns/1ps
// Systolic array top level
// Host byte writes into activation and weight memories, run control,
// the cell grid and the output collector
module sa_top #(
    parameter int N_ROW      = sa_geom_pkg::N_ROW,
    parameter int N_COL      = sa_geom_pkg::N_COL,
    parameter int DATA_DEPTH = sa_geom_pkg::DATA_DEPTH
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start_i,
    input  sa_word_pkg::len_t                     burst_len_i,
    input  logic                                  wr_en_i,
    input  logic [sa_geom_pkg::HADDR_W-1:0]       wr_addr_i,
    input  logic [sa_word_pkg::ACT_W-1:0]         wr_data_i,
    // Column 0 in the low bits
    output logic [N_COL*sa_word_pkg::ACC_W-1:0]   acc_data_o,
    output logic                                  acc_valid_o,
    output logic                                  done_o,
    output logic                                  busy_o
);
    import sa_geom_pkg::*;
    import sa_word_pkg::*;

    logic             ld_en;
    logic [ROW_W-1:0] ld_row;
    logic             rd_en;
    vec_idx_t         rd_addr;
    logic             rd_last;
    acc_t [N_COL-1:0] col_sum;
    logic             vec_valid;
    logic             vec_last;

    sa_feed_if #(.N_ROW(N_ROW), .N_COL(N_COL)) feed ();

    sa_ctrl #(.N_ROW(N_ROW), .DATA_DEPTH(DATA_DEPTH)) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .burst_len_i (burst_len_i),
        .done_i      (done_o),
        .busy_o      (busy_o),
        .ld_en_o     (ld_en),
        .ld_row_o    (ld_row),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .rd_last_o   (rd_last)
    );

    data_buffer #(.N_ROW(N_ROW), .DATA_DEPTH(DATA_DEPTH)) u_data_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_last_i (rd_last),
        .feed      (feed)
    );

    weight_bram #(.N_ROW(N_ROW), .N_COL(N_COL)) u_weight_bram (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .ld_en_i   (ld_en),
        .ld_row_i  (ld_row),
        .feed      (feed)
    );

    systolic_array #(.N_ROW(N_ROW), .N_COL(N_COL)) u_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .feed        (feed),
        .col_sum_o   (col_sum),
        .vec_valid_o (vec_valid),
        .vec_last_o  (vec_last)
    );

    out_collector #(.N_ROW(N_ROW), .N_COL(N_COL)) u_out_collector (
        .clk         (clk),
        .rst_n       (rst_n),
        .col_sum_i   (col_sum),
        .vec_valid_i (vec_valid),
        .vec_last_i  (vec_last),
        .acc_data_o  (acc_data_o),
        .acc_valid_o (acc_valid_o),
        .done_o      (done_o)
    );

endmodule

/* design/out_collector.sv */
`timescale 1ns/1ps
// Output collector
// Undoes the column skew so one vector's sums leave together,
// and lines up valid and last with them
module out_collector #(
    parameter int N_ROW = sa_geom_pkg::N_ROW,
    parameter int N_COL = sa_geom_pkg::N_COL
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sa_word_pkg::acc_t [N_COL-1:0] col_sum_i,
    input  logic                          vec_valid_i,
    input  logic                          vec_last_i,
    output sa_word_pkg::acc_t [N_COL-1:0] acc_data_o,
    output logic                          acc_valid_o,
    output logic                          done_o
);
    import sa_word_pkg::*;

    // Includes the output register
    localparam int TAG_DLY = N_ROW + N_COL - 1;

    acc_t [N_COL-1:0]   aligned;
    logic [TAG_DLY-1:0] valid_sr;
    logic [TAG_DLY-1:0] last_sr;

    // Leftmost column waits longest
    for (genvar c = 0; c < N_COL; c++) begin : g_deskew
        localparam int D = N_COL - 1 - c;
        if (D == 0) begin : g_pass
            assign aligned[c] = col_sum_i[c];
        end else begin : g_delay
            acc_t dly_q [D];
            always_ff @(posedge clk) begin
                dly_q[0] <= col_sum_i[c];
                for (int k = 1; k < D; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end
            assign aligned[c] = dly_q[D-1];
        end
    end

    always_ff @(posedge clk) begin
        acc_data_o <= aligned;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
            last_sr  <= '0;
        end else begin
            valid_sr <= (valid_sr << 1) | TAG_DLY'(vec_valid_i);
            last_sr  <= (last_sr << 1) | TAG_DLY'(vec_last_i);
        end
    end

    assign acc_valid_o = valid_sr[TAG_DLY-1];
    assign done_o      = last_sr[TAG_DLY-1];

endmodule

/* design/systolic_array.sv */
`timescale 1ns/1ps
// Weight-stationary systolic array
// Skews each activation row, runs it across the cell grid and
// collects the column sums at the bottom row
module systolic_array #(
    parameter int N_ROW = sa_geom_pkg::N_ROW,
    parameter int N_COL = sa_geom_pkg::N_COL
) (
    input  logic                          clk,
    input  logic                          rst_n,
    sa_feed_if.array                      feed,
    output sa_word_pkg::acc_t [N_COL-1:0] col_sum_o,
    output logic                          vec_valid_o,
    output logic                          vec_last_o
);
    import sa_geom_pkg::*;
    import sa_word_pkg::*;

    act_t             a_h [N_ROW][N_COL+1];
    acc_t             p_v [N_ROW+1][N_COL];
    logic [N_ROW-1:0] row_load;

    // Row r enters column 0 r cycles late
    for (genvar r = 0; r < N_ROW; r++) begin : g_skew
        if (r == 0) begin : g_direct
            assign a_h[r][0] = feed.d_vec[r];
        end else begin : g_delay
            act_t skew_q [r];
            always_ff @(posedge clk) begin
                skew_q[0] <= feed.d_vec[r];
                for (int k = 1; k < r; k++) begin
                    skew_q[k] <= skew_q[k-1];
                end
            end
            assign a_h[r][0] = skew_q[r-1];
        end
        assign row_load[r] = feed.w_load && (feed.w_row == ROW_W'(r));
    end

    for (genvar c = 0; c < N_COL; c++) begin : g_col
        assign p_v[0][c]    = '0;
        assign col_sum_o[c] = p_v[N_ROW][c];
    end

    for (genvar r = 0; r < N_ROW; r++) begin : g_row
        for (genvar c = 0; c < N_COL; c++) begin : g_cell
            sa_pe u_pe (
                .clk      (clk),
                .rst_n    (rst_n),
                .w_load_i (row_load[r]),
                .w_i      (feed.w_vec[c]),
                .a_i      (a_h[r][c]),
                .a_o      (a_h[r][c+1]),
                .psum_i   (p_v[r][c]),
                .psum_o   (p_v[r+1][c])
            );
        end
    end

    // Strobes follow the vector into the first cell
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_valid_o <= 1'b0;
            vec_last_o  <= 1'b0;
        end else begin
            vec_valid_o <= feed.d_valid;
            vec_last_o  <= feed.d_last;
        end
    end

endmodule

/* design/weight_bram.sv */
`timescale 1ns/1ps
// Column-banked weight memory
// One bank per column, a load reads the same row from all banks at once
module weight_bram #(
    parameter int N_ROW = sa_geom_pkg::N_ROW,
    parameter int N_COL = sa_geom_pkg::N_COL
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en_i,
    input  logic [sa_geom_pkg::HADDR_W-1:0] wr_addr_i,
    input  sa_word_pkg::wgt_t               wr_data_i,
    input  logic                            ld_en_i,
    input  logic [sa_geom_pkg::ROW_W-1:0]   ld_row_i,
    sa_feed_if.weight_src                   feed
);
    import sa_geom_pkg::*;
    import sa_word_pkg::*;

    wgt_t             bank [N_COL][N_ROW];
    logic             wgt_we;
    logic [COL_W-1:0] wr_col;
    logic [ROW_W-1:0] wr_row;

    assign wgt_we = wr_en_i && wr_addr_i[SEL_BIT];
    assign wr_col = wr_addr_i[COL_LSB +: COL_W];
    assign wr_row = wr_addr_i[ROW_W-1:0];

    // Column field picks the bank
    always_ff @(posedge clk) begin
        for (int c = 0; c < N_COL; c++) begin
            if (wgt_we && wr_col == COL_W'(c)) begin
                bank[c][wr_row] <= wr_data_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_en_i) begin
            for (int c = 0; c < N_COL; c++) begin
                feed.w_vec[c] <= bank[c][ld_row_i];
            end
        end
        feed.w_row <= ld_row_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            feed.w_load <= 1'b0;
        end else begin
            feed.w_load <= ld_en_i;
        end
    end

endmodule

/* design/data_buffer.sv */
`timescale 1ns/1ps
// Activation buffer
// Host writes one byte into a row lane, the array side reads a whole vector
// across all lanes per request, one cycle later
module data_buffer #(
    parameter int N_ROW      = sa_geom_pkg::N_ROW,
    parameter int DATA_DEPTH = sa_geom_pkg::DATA_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en_i,
    input  logic [sa_geom_pkg::HADDR_W-1:0] wr_addr_i,
    input  sa_word_pkg::act_t               wr_data_i,
    input  logic                            rd_en_i,
    input  sa_word_pkg::vec_idx_t           rd_addr_i,
    input  logic                            rd_last_i,
    sa_feed_if.data_src                     feed
);
    import sa_geom_pkg::*;
    import sa_word_pkg::*;

    act_t             mem [N_ROW][DATA_DEPTH];
    logic             data_we;
    logic [ROW_W-1:0] wr_lane;
    vec_idx_t         wr_vec;

    // Select bit low addresses the data side
    assign data_we = wr_en_i && !wr_addr_i[SEL_BIT];
    assign wr_lane = wr_addr_i[ROW_W-1:0];
    assign wr_vec  = wr_addr_i[VEC_LSB +: VEC_W];

    always_ff @(posedge clk) begin
        for (int r = 0; r < N_ROW; r++) begin
            if (data_we && wr_lane == ROW_W'(r)) begin
                mem[r][wr_vec] <= wr_data_i;
            end
        end
    end

    // Same vector index from every lane
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int r = 0; r < N_ROW; r++) begin
                feed.d_vec[r] <= mem[r][rd_addr_i];
            end
        end
    end

    // Strobes track the registered read data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            feed.d_valid <= 1'b0;
            feed.d_last  <= 1'b0;
        end else begin
            feed.d_valid <= rd_en_i;
            feed.d_last  <= rd_en_i && rd_last_i;
        end
    end

endmodule

/* design/sa_ctrl.sv */
`timescale 1ns/1ps
// Run controller
// Loads the weight rows, streams the burst of activation vectors,
// then holds busy until the output side reports the last result
module sa_ctrl #(
    parameter int N_ROW      = sa_geom_pkg::N_ROW,
    parameter int DATA_DEPTH = sa_geom_pkg::DATA_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  sa_word_pkg::len_t             burst_len_i,
    input  logic                          done_i,
    output logic                          busy_o,
    output logic                          ld_en_o,
    output logic [sa_geom_pkg::ROW_W-1:0] ld_row_o,
    output logic                          rd_en_o,
    output sa_word_pkg::vec_idx_t         rd_addr_o,
    output logic                          rd_last_o
);
    import sa_geom_pkg::*;
    import sa_word_pkg::*;

    ctrl_state_t      state;
    len_t             len_q;
    logic [ROW_W-1:0] row_cnt;
    vec_idx_t         vec_cnt;
    logic             last_row;
    logic             last_vec;

    assign last_row = (row_cnt == ROW_W'(N_ROW - 1));
    assign last_vec = (len_t'(vec_cnt) == len_q - len_t'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            len_q   <= '0;
            row_cnt <= '0;
            vec_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    row_cnt <= '0;
                    vec_cnt <= '0;
                    // Zero length is a no-op
                    if (start_i && burst_len_i != '0) begin
                        if (burst_len_i > len_t'(DATA_DEPTH)) begin
                            len_q <= len_t'(DATA_DEPTH);
                        end else begin
                            len_q <= burst_len_i;
                        end
                        state <= LOAD_W;
                    end
                end
                LOAD_W: begin
                    row_cnt <= row_cnt + 1'b1;
                    if (last_row) begin
                        state <= STREAM;
                    end
                end
                STREAM: begin
                    vec_cnt <= vec_cnt + 1'b1;
                    if (last_vec) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Wait for the last result to leave the collector
                    if (done_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy_o    = (state != IDLE);
    assign ld_en_o   = (state == LOAD_W);
    assign ld_row_o  = row_cnt;
    assign rd_en_o   = (state == STREAM);
    assign rd_addr_o = vec_cnt;
    assign rd_last_o = rd_en_o && last_vec;

endmodule

/* design/sa_pe.sv */
`timescale 1ns/1ps
// Processing element
// Holds a stationary weight, passes its activation to the right
// and adds its product to the partial sum coming from above
module sa_pe (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              w_load_i,
    input  sa_word_pkg::wgt_t w_i,
    input  sa_word_pkg::act_t a_i,
    output sa_word_pkg::act_t a_o,
    input  sa_word_pkg::acc_t psum_i,
    output sa_word_pkg::acc_t psum_o
);
    import sa_word_pkg::*;

    wgt_t w_q;
    acc_t prod;

    // Unsigned operands widened before the multiply
    assign prod = acc_t'(a_i) * acc_t'(w_q);

    always_ff @(posedge clk) begin
        if (w_load_i) begin
            w_q <= w_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_o    <= '0;
            psum_o <= '0;
        end else begin
            a_o    <= a_i;
            psum_o <= psum_i + prod;
        end
    end

endmodule

/* design/sa_feed_if.sv */
`timescale 1ns/1ps
// Array feed
// Activation vectors from the data buffer and weight rows from the weight memory
interface sa_feed_if #(
    parameter int N_ROW = sa_geom_pkg::N_ROW,
    parameter int N_COL = sa_geom_pkg::N_COL
);
    import sa_geom_pkg::*;
    import sa_word_pkg::*;

    // Activation stream with one vector per valid cycle
    logic             d_valid;
    logic             d_last;
    act_t [N_ROW-1:0] d_vec;

    // Weight row load
    logic             w_load;
    logic [ROW_W-1:0] w_row;
    wgt_t [N_COL-1:0] w_vec;

    modport data_src (output d_valid, d_last, d_vec);

    modport weight_src (output w_load, w_row, w_vec);

    modport array (
        input d_valid, d_last, d_vec,
        input w_load, w_row, w_vec
    );

endinterface

/* design/sa_word_pkg.sv */
// Systolic array word types
// Operand and sum widths, buffer index, burst length and controller states
package sa_word_pkg;

    localparam int ACT_W = 8;
    localparam int WGT_W = 8;
    // Room for 16 taps of 16-bit products
    localparam int ACC_W = 20;

    // Unsigned operands
    typedef logic [ACT_W-1:0] act_t;
    typedef logic [WGT_W-1:0] wgt_t;

    // Full-width column sum
    typedef logic [ACC_W-1:0] acc_t;

    // Vector index in the activation buffer
    typedef logic [sa_geom_pkg::VEC_W-1:0] vec_idx_t;

    // One extra bit so a full buffer fits
    typedef logic [sa_geom_pkg::VEC_W:0] len_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_W,
        STREAM,
        DRAIN
    } ctrl_state_t;

endpackage

/* design/sa_geom_pkg.sv */
// Systolic array geometry
// Array shape, activation buffer depth and host address map
package sa_geom_pkg;

    // Array shape and buffer size
    localparam int N_ROW      = 4;
    localparam int N_COL      = 4;
    localparam int DATA_DEPTH = 64;

    // Field widths never narrower than one bit
    localparam int ROW_W = (N_ROW > 1) ? $clog2(N_ROW) : 1;
    localparam int COL_W = (N_COL > 1) ? $clog2(N_COL) : 1;
    localparam int VEC_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;

    // Host map with data at {vec, row}, weight at {col, row} and the select bit on top
    localparam int VEC_LSB = ROW_W;
    localparam int COL_LSB = ROW_W;
    localparam int DATA_AW = VEC_W + ROW_W;
    localparam int WGT_AW  = COL_W + ROW_W;
    localparam int HADDR_W = ((DATA_AW > WGT_AW) ? DATA_AW : WGT_AW) + 1;
    localparam int SEL_BIT = HADDR_W - 1;

endpackage
